// ==== design/game_defines.svh ====
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// Number of chasing enemies built into the field
`define ENEMY_COUNT 2

// Enemy sprite box
`define SPRITE_W 26
`define SPRITE_H 26

// Player collision box
`define PLAYER_W 18
`define PLAYER_H 20

// Walkable rectangle, inclusive bounds
`define X_MIN 0
`define X_MAX 319
`define Y_MIN 52
`define Y_MAX 205

`define STEP 2       // Pixels per frame tick

`define COORD_W 9    // Screen coordinate width
`define ADDR_W 13    // Shared sprite ROM address width

`endif

// ==== design/game_pkg.sv ====
`include "game_defines.svh"

package game_pkg;

    // Facing order matches the sprite ROM layout, three frames per direction
    typedef enum logic [1:0] {
        dirDown  = 2'd0,
        dirLeft  = 2'd1,
        dirUp    = 2'd2,
        dirRight = 2'd3
    } dir_e;

    typedef enum logic [1:0] {
        regPlayerPos = 2'd0,
        regAlive     = 2'd1,
        regFreeze    = 2'd2
    } regAddr_e;

    typedef struct packed {
        logic [`COORD_W-1:0] x;
        logic [`COORD_W-1:0] y;
    } regPos_t;

    typedef struct packed {
        logic [2*`COORD_W-`ENEMY_COUNT-1:0] spare;
        logic [`ENEMY_COUNT-1:0]            mask;    // One bit per enemy
    } regCtrl_t;

    // Host write word, decoded by register address
    typedef union packed {
        regPos_t  pos;
        regCtrl_t ctrl;
    } regWord_u;

endpackage

// ==== design/enemyRegs.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyRegs (
    input  logic                     Clk,
    input  logic                     rstN,
    input  logic                     wrEn,
    input  game_pkg::regAddr_e       wrAddr,
    input  game_pkg::regWord_u       wrData,
    output logic [`COORD_W-1:0]      playerX,
    output logic [`COORD_W-1:0]      playerY,
    output logic [`ENEMY_COUNT-1:0]  aliveMask,
    output logic [`ENEMY_COUNT-1:0]  freezeMask
);
    import game_pkg::*;

    localparam int CW = `COORD_W;

    // Player parks in the middle of the screen until the host moves it
    localparam logic [CW-1:0] PLAYER_X0 = CW'(160);
    localparam logic [CW-1:0] PLAYER_Y0 = CW'(120);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            playerX    <= PLAYER_X0;
            playerY    <= PLAYER_Y0;
            aliveMask  <= '1;        // Every enemy starts alive
            freezeMask <= '0;
        end else if (wrEn) begin
            case (wrAddr)
                regPlayerPos: begin
                    playerX <= wrData.pos.x;
                    playerY <= wrData.pos.y;
                end
                regAlive: begin
                    aliveMask <= wrData.ctrl.mask;
                end
                regFreeze: begin
                    freezeMask <= wrData.ctrl.mask;
                end
                default: begin
                    // Unmapped address, write is dropped
                end
            endcase
        end
    end

endmodule

// ==== design/enemyWalkCounter.sv ====
`timescale 1ns/1ns

module enemyWalkCounter (
    input  logic       Clk,
    input  logic       rstN,
    input  logic       frameTick,
    input  logic       moving,
    output logic [1:0] stepCount
);

    // Walking phase for the animation
    // Wraps through 0..3 while the enemy keeps moving
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            stepCount <= 2'd0;
        end else if (frameTick) begin
            if (moving)
                stepCount <= stepCount + 2'd1;
            else
                stepCount <= 2'd0;     // Standing enemy falls back to rest frame
        end
    end

endmodule

// ==== design/enemyChaser.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyChaser #(
    parameter int enemyId = 0
) (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 frameTick,
    input  logic                 alive,
    input  logic                 freeze,
    input  logic [`COORD_W-1:0]  playerX,
    input  logic [`COORD_W-1:0]  playerY,
    input  logic [`COORD_W-1:0]  pixelX,
    input  logic [`COORD_W-1:0]  pixelY,
    output logic [`COORD_W-1:0]  posX,
    output logic [`COORD_W-1:0]  posY,
    output game_pkg::dir_e       facing,
    output logic                 attackReady,
    output logic                 hit,
    output logic [`ADDR_W-1:0]   spriteAddr
);
    import game_pkg::*;

    localparam int CW = `COORD_W;
    localparam int EW = `COORD_W + 1;
    localparam int AW = `ADDR_W;

    // Top-left corner derived from the sprite center of each enemy
    localparam logic [CW-1:0] START_X = CW'(70 * (enemyId + 1) - `SPRITE_W / 2);
    localparam logic [CW-1:0] START_Y = CW'(40 * (enemyId + 1) - `SPRITE_H / 2);

    logic [EW-1:0] rightEdge;
    logic [EW-1:0] bottomEdge;
    logic [EW-1:0] playerRight;
    logic [EW-1:0] playerBottom;
    logic          stepEn;
    logic          moving;
    logic [CW-1:0] nextX;
    logic [CW-1:0] nextY;
    dir_e          facingNext;
    logic [1:0]    stepCount;
    logic          inBox;
    logic [CW-1:0] dx;
    logic [CW-1:0] dy;
    logic [3:0]    frameIdx;

    // Edges are one bit wider so the sums never wrap
    assign rightEdge    = EW'(posX) + EW'(`SPRITE_W);
    assign bottomEdge   = EW'(posY) + EW'(`SPRITE_H);
    assign playerRight  = EW'(playerX) + EW'(`PLAYER_W);
    assign playerBottom = EW'(playerY) + EW'(`PLAYER_H);

    assign stepEn = frameTick & alive & ~freeze;

    // Horizontal chase first, vertical only once x is aligned
    always_comb begin
        nextX      = posX;
        nextY      = posY;
        facingNext = facing;
        if (rightEdge < EW'(playerX)) begin
            facingNext = dirRight;
            if (rightEdge < EW'(`X_MAX))
                nextX = posX + CW'(`STEP);
        end else if (EW'(posX) > playerRight) begin
            facingNext = dirLeft;
            if (posX > CW'(`X_MIN))
                nextX = (posX < CW'(`X_MIN + `STEP)) ? CW'(`X_MIN) : posX - CW'(`STEP);
        end else if (bottomEdge < EW'(playerY)) begin
            facingNext = dirDown;
            if (bottomEdge < EW'(`Y_MAX))
                nextY = posY + CW'(`STEP);
        end else if (EW'(posY) > playerBottom) begin
            facingNext = dirUp;
            if (posY > CW'(`Y_MIN))
                nextY = (posY < CW'(`Y_MIN + `STEP)) ? CW'(`Y_MIN) : posY - CW'(`STEP);
        end
    end

    assign moving = stepEn && ((nextX != posX) || (nextY != posY));

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            posX        <= START_X;
            posY        <= START_Y;
            facing      <= dirDown;
            attackReady <= 1'b0;
        end else if (!alive) begin
            attackReady <= 1'b0;            // Dead enemy stays where it fell
        end else if (stepEn) begin
            posX        <= nextX;
            posY        <= nextY;
            facing      <= facingNext;
            attackReady <= ~moving;         // Blocked next to the player
        end
    end

    enemyWalkCounter enemyWalkCounter_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .frameTick (frameTick),
        .moving    (moving),
        .stepCount (stepCount)
    );

    assign inBox = (pixelX >= posX) && (EW'(pixelX) < rightEdge) &&
                   (pixelY >= posY) && (EW'(pixelY) < bottomEdge);
    assign hit   = alive & inBox;

    assign dx = pixelX - posX;
    assign dy = pixelY - posY;

    // Odd phases show a stride frame, even phases the rest frame
    assign frameIdx = {2'b00, facing} * 4'd3 +
                      (stepCount[0] ? 4'd1 + {3'b000, stepCount[1]} : 4'd0);

    assign spriteAddr = hit ? AW'(dx) + AW'(dy) * AW'(`SPRITE_W) +
                              AW'(frameIdx) * AW'(`SPRITE_W * `SPRITE_H)
                            : '0;

endmodule

// ==== design/enemyPixelMux.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyPixelMux (
    input  logic [`ENEMY_COUNT-1:0]         hitVec,
    input  logic [`ENEMY_COUNT*`ADDR_W-1:0] addrVec,
    output logic                            enemyHit,
    output logic [`ADDR_W-1:0]              enemyAddr,
    output logic [$clog2(`ENEMY_COUNT)-1:0] enemyIndex
);

    localparam int IW = $clog2(`ENEMY_COUNT);

    // Scan from the top index down so the lowest hit enemy wins
    always_comb begin
        enemyHit   = 1'b0;
        enemyAddr  = '0;
        enemyIndex = '0;
        for (int i = `ENEMY_COUNT - 1; i >= 0; i--) begin
            if (hitVec[i]) begin
                enemyHit   = 1'b1;
                enemyAddr  = addrVec[i*`ADDR_W +: `ADDR_W];
                enemyIndex = IW'(i);
            end
        end
    end

endmodule

// ==== design/enemyField.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyField (
    input  logic                             Clk,
    input  logic                             rstN,
    input  logic                             frameTick,
    input  logic                             wrEn,
    input  game_pkg::regAddr_e               wrAddr,
    input  game_pkg::regWord_u               wrData,
    input  logic [`COORD_W-1:0]              pixelX,
    input  logic [`COORD_W-1:0]              pixelY,
    output logic                             enemyHit,
    output logic [`ADDR_W-1:0]               enemyAddr,
    output logic [$clog2(`ENEMY_COUNT)-1:0]  enemyIndex,
    output logic [`ENEMY_COUNT-1:0]          attackReadyVec,
    output logic [`ENEMY_COUNT*`COORD_W-1:0] posXVec,
    output logic [`ENEMY_COUNT*`COORD_W-1:0] posYVec
);

    logic [`COORD_W-1:0]              playerX;
    logic [`COORD_W-1:0]              playerY;
    logic [`ENEMY_COUNT-1:0]          aliveMask;
    logic [`ENEMY_COUNT-1:0]          freezeMask;
    logic [`ENEMY_COUNT-1:0]          hitVec;
    logic [`ENEMY_COUNT*`ADDR_W-1:0]  addrVec;

    enemyRegs enemyRegs_i (
        .Clk        (Clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .playerX    (playerX),
        .playerY    (playerY),
        .aliveMask  (aliveMask),
        .freezeMask (freezeMask)
    );

    for (genvar k = 0; k < `ENEMY_COUNT; k++) begin : genChaser
        enemyChaser #(
            .enemyId (k)
        ) enemyChaser_i (
            .Clk         (Clk),
            .rstN        (rstN),
            .frameTick   (frameTick),
            .alive       (aliveMask[k]),
            .freeze      (freezeMask[k]),
            .playerX     (playerX),
            .playerY     (playerY),
            .pixelX      (pixelX),
            .pixelY      (pixelY),
            .posX        (posXVec[k*`COORD_W +: `COORD_W]),
            .posY        (posYVec[k*`COORD_W +: `COORD_W]),
            .facing      (),                      // Observed only inside the chaser
            .attackReady (attackReadyVec[k]),
            .hit         (hitVec[k]),
            .spriteAddr  (addrVec[k*`ADDR_W +: `ADDR_W])
        );
    end

    enemyPixelMux enemyPixelMux_i (
        .hitVec     (hitVec),
        .addrVec    (addrVec),
        .enemyHit   (enemyHit),
        .enemyAddr  (enemyAddr),
        .enemyIndex (enemyIndex)
    );

endmodule

// ==== tests/enemyField_checker.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyField_checker (
    input logic                             Clk,
    input logic                             rstN,
    input logic                             frameTick,
    input logic [`ENEMY_COUNT-1:0]          aliveMask,
    input logic [`ENEMY_COUNT-1:0]          attackReadyVec,
    input logic [`ENEMY_COUNT*`COORD_W-1:0] posXVec,
    input logic [`ENEMY_COUNT*`COORD_W-1:0] posYVec
);

    for (genvar k = 0; k < `ENEMY_COUNT; k++) begin : genCheck
        // A killed enemy drops its attack level on the next edge
        attackDrop: assert property (@(posedge Clk) disable iff (!rstN)
            $fell(aliveMask[k]) |=> !attackReadyVec[k])
            else $error("enemy %0d kept attackReady after death", k);

        posNeedsTick: assert property (@(posedge Clk) disable iff (!rstN)
            !$past(frameTick) |-> ($stable(posXVec[k*`COORD_W +: `COORD_W]) &&
                                   $stable(posYVec[k*`COORD_W +: `COORD_W])))
            else $error("enemy %0d moved without a frame tick", k);

        // Far edges of the sprite box stay inside the walkable area
        inField: assert property (@(posedge Clk) disable iff (!rstN)
            ((posXVec[k*`COORD_W +: `COORD_W] + 10'(`SPRITE_W)) <= 10'(`X_MAX + 1)) &&
            ((posYVec[k*`COORD_W +: `COORD_W] + 10'(`SPRITE_H)) <= 10'(`Y_MAX + 1)))
            else $error("enemy %0d left the walkable rectangle", k);
    end

endmodule

bind enemyField enemyField_checker enemyField_checker_i (
    .Clk            (Clk),
    .rstN           (rstN),
    .frameTick      (frameTick),
    .aliveMask      (aliveMask),
    .attackReadyVec (attackReadyVec),
    .posXVec        (posXVec),
    .posYVec        (posYVec)
);

// ==== tests/enemyField_tb.sv ====
`timescale 1ns/1ns
`include "game_defines.svh"

module enemyField_tb;
    import game_pkg::*;

    localparam int ROWS = 8;
    localparam int TICK_CYCLES = 3;    // Clock cycles spent per frame tick
    localparam int PERIOD = 8;

    typedef struct {
        int px, py, alive, freeze, ticks;
        int x0, y0, x1, y1, att, f0, f1, s0, s1;
    } row_t;

    logic Clk, rstN, frameTick, wrEn;
    regAddr_e wrAddr;
    regWord_u wrData;
    logic [`COORD_W-1:0] pixelX, pixelY;
    logic enemyHit;
    logic [`ADDR_W-1:0] enemyAddr;
    logic [$clog2(`ENEMY_COUNT)-1:0] enemyIndex;
    logic [`ENEMY_COUNT-1:0] attackReadyVec;
    logic [`ENEMY_COUNT*`COORD_W-1:0] posXVec, posYVec;

    row_t rows [ROWS];
    int errors = 0;
    int checks = 0;
    integer seed = 32'h46600333;

    enemyField enemyField_i (.*);

    initial begin
        Clk = 1'b0;
        forever #(PERIOD / 2) Clk = ~Clk;
    end

    // Hand-worked expectations, positions are top-left corners
    initial begin
        rows[0] = '{160, 120, 3, 0, 0,   57, 27, 127, 67, 0, 0, 0, 0, 0};
        rows[1] = '{300, 230, 3, 0, 10,  77, 27, 147, 67, 0, 3, 3, 2, 2};
        rows[2] = '{300, 230, 3, 0, 200, 275, 179, 275, 179, 3, 0, 0, 0, 0};
        rows[3] = '{200, 100, 3, 0, 1,   273, 179, 273, 179, 0, 1, 1, 1, 1};
        rows[4] = '{265, 170, 3, 0, 1,   273, 179, 273, 179, 3, 1, 1, 0, 0};
        rows[5] = '{265, 170, 1, 0, 1,   273, 179, 273, 179, 1, 1, 1, 0, 0};
        rows[6] = '{100, 100, 1, 0, 3,   267, 179, 273, 179, 0, 1, 1, 3, 0};
        rows[7] = '{100, 100, 3, 1, 2,   267, 179, 269, 179, 0, 1, 1, 0, 2};
    end

    task automatic writeReg(regAddr_e a, int x, int y, int mask);
        regWord_u w;
        if (a == regPlayerPos) begin
            w.pos.x = `COORD_W'(x);
            w.pos.y = `COORD_W'(y);
        end else begin
            w.ctrl.spare = '0;
            w.ctrl.mask = `ENEMY_COUNT'(mask);
        end
        @(posedge Clk);
        wrEn <= 1'b1;
        wrAddr <= a;
        wrData <= w;
        @(posedge Clk);
        wrEn <= 1'b0;
    endtask

    task automatic issueTicks(int n);
        repeat (n) begin
            @(posedge Clk);
            frameTick <= 1'b1;
            @(posedge Clk);
            frameTick <= 1'b0;
            @(posedge Clk);
        end
    endtask

    task automatic checkValue(string what, int got, int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    function automatic int spriteAddress(int dx, int dy, int face, int step);
        int frame;
        frame = 3 * face + ((step % 2) ? 1 + step / 2 : 0);
        return dx + dy * `SPRITE_W + frame * `SPRITE_W * `SPRITE_H;
    endfunction

    // Expected video outputs for one pixel, lowest enemy id drawn on top
    task automatic probePixel(row_t r, int x, int y);
        int ex[2], ey[2], ef[2], es[2];
        int expHit, expAddr, expIdx;
        ex = '{r.x0, r.x1};
        ey = '{r.y0, r.y1};
        ef = '{r.f0, r.f1};
        es = '{r.s0, r.s1};
        expHit = 0;
        expAddr = 0;
        expIdx = 0;
        for (int k = 1; k >= 0; k--) begin
            if (r.alive[k] && x >= ex[k] && x < ex[k] + `SPRITE_W &&
                y >= ey[k] && y < ey[k] + `SPRITE_H) begin
                expHit = 1;
                expIdx = k;
                expAddr = spriteAddress(x - ex[k], y - ey[k], ef[k], es[k]);
            end
        end
        @(posedge Clk);
        pixelX <= `COORD_W'(x);
        pixelY <= `COORD_W'(y);
        @(negedge Clk);
        checkValue($sformatf("enemyHit at (%0d,%0d)", x, y), enemyHit, expHit);
        checkValue($sformatf("enemyAddr at (%0d,%0d)", x, y), enemyAddr, expAddr);
        checkValue($sformatf("enemyIndex at (%0d,%0d)", x, y), enemyIndex, expIdx);
    endtask

    initial begin
        int totalTicks;
        #1;
        totalTicks = 0;
        for (int i = 0; i < ROWS; i++)
            totalTicks += rows[i].ticks;
        #((totalTicks * TICK_CYCLES + ROWS * 200 + 500) * PERIOD);
        $display("Timeout: the test did not finish in the expected time");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        row_t r;
        rstN = 1'b0;
        frameTick = 1'b0;
        wrEn = 1'b0;
        wrAddr = regPlayerPos;
        wrData = '0;
        pixelX = '0;
        pixelY = '0;
        repeat (3) @(posedge Clk);
        rstN <= 1'b1;
        #1;
        for (int i = 0; i < ROWS; i++) begin
            r = rows[i];
            writeReg(regPlayerPos, r.px, r.py, 0);
            writeReg(regAlive, 0, 0, r.alive);
            writeReg(regFreeze, 0, 0, r.freeze);
            issueTicks(r.ticks);
            @(negedge Clk);
            checkValue($sformatf("row %0d posX0", i), posXVec[8:0], r.x0);
            checkValue($sformatf("row %0d posY0", i), posYVec[8:0], r.y0);
            checkValue($sformatf("row %0d posX1", i), posXVec[17:9], r.x1);
            checkValue($sformatf("row %0d posY1", i), posYVec[17:9], r.y1);
            checkValue($sformatf("row %0d attackReady", i), attackReadyVec, r.att);
            checkValue($sformatf("row %0d facing0", i),
                       enemyField_i.genChaser[0].enemyChaser_i.facing, r.f0);
            checkValue($sformatf("row %0d facing1", i),
                       enemyField_i.genChaser[1].enemyChaser_i.facing, r.f1);
            // Box centers, corners, then random probes around the sprites
            probePixel(r, r.x0 + 13, r.y0 + 13);
            probePixel(r, r.x1 + 13, r.y1 + 13);
            probePixel(r, r.x1 + 25, r.y1 + 25);
            probePixel(r, r.x0 + 26, r.y0);
            repeat (12) begin
                probePixel(r, r.x0 - 8 + ($unsigned($random(seed)) % 80),
                           r.y0 - 8 + ($unsigned($random(seed)) % 80));
            end
        end
        $display("Checks run %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+design
design/game_pkg.sv
design/enemyRegs.sv
design/enemyWalkCounter.sv
design/enemyChaser.sv
design/enemyPixelMux.sv
design/enemyField.sv
tests/enemyField_checker.sv
tests/enemyField_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= enemyField_tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@if ! grep -q "PASS: all tests" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
